// ==== src/dma_path_pkg.sv ====
`default_nettype none

package dma_path_pkg;

	////////////////////////////////////////////////////////////
	// data path types
	////////////////////////////////////////////////////////////

	typedef logic [127:0] beat_t;       // one client or dram beat
	typedef logic [71:0]  cmd_t;        // low header bits, command word
	typedef logic [39:0]  dram_addr_t;
	typedef logic [15:0]  dpram_addr_t;
	typedef logic [15:0]  burst_len_t;  // beats incl. header
	typedef logic [7:0]   msg_form_t;

	////////////////////////////////////////////////////////////
	// header layout
	////////////////////////////////////////////////////////////

	parameter int DRAM_ADDR_LSB  = 0;
	parameter int DPRAM_ADDR_LSB = 40;
	parameter int LEN_LSB        = 56;
	parameter int FORM_LSB       = 72;

	// message forms
	parameter msg_form_t MSG_READ_CMD  = 8'h01;
	parameter msg_form_t MSG_WRITE_CMD = 8'h03;

endpackage

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH      = 128,
	parameter int DEPTH_LOG2 = 4
) (
	input  logic             fpu_clk,
	input  logic             reset,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;   // one extra bit, top bit set only when full
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr_en && !full;   // drop writes when full
	assign do_rd = rd_en && !empty;  // and reads when empty

	always_ff @(posedge fpu_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head entry falls through
	assign rd_data = mem[rd_ptr];
	assign full    = count[DEPTH_LOG2];
	assign empty   = (count == '0);

endmodule

`default_nettype wire

// ==== src/client_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module client_arbiter (
	input  logic                fpu_clk,
	input  logic                reset,
	input  logic                dma_req_a,
	input  logic                dma_req_b,
	input  logic                dma_req_c,
	input  logic                dma_req_d,
	input  logic                dma_write_valid_a,
	input  logic                dma_write_valid_b,
	input  logic                dma_write_valid_c,
	input  logic                dma_write_valid_d,
	input  dma_path_pkg::beat_t dma_write_data_a,
	input  dma_path_pkg::beat_t dma_write_data_b,
	input  dma_path_pkg::beat_t dma_write_data_c,
	input  dma_path_pkg::beat_t dma_write_data_d,
	output logic                dma_resp_a,
	output logic                dma_resp_b,
	output logic                dma_resp_c,
	output logic                dma_resp_d,
	output logic                dma_write_ready_a,
	output logic                dma_write_ready_b,
	output logic                dma_write_ready_c,
	output logic                dma_write_ready_d,
	output logic                intake_valid,
	output dma_path_pkg::beat_t intake_beat,
	input  logic                intake_full
);

	typedef enum logic [1:0] {arb_idle, arb_granted, arb_burst, arb_done} arb_state_t;

	arb_state_t                 state;
	logic [1:0]                 sel;        // granted client, a = 0
	logic [1:0]                 last;       // most recently served
	logic [1:0]                 pick;
	logic                       pick_valid;
	logic [3:0]                 req;
	logic                       resp_r;     // high until header accepted
	logic                       sel_valid;
	logic                       write_ready;
	logic                       accept;
	dma_path_pkg::burst_len_t   hdr_len;
	dma_path_pkg::burst_len_t   burst_len;
	dma_path_pkg::burst_len_t   beat_cnt;

	assign req = {dma_req_d, dma_req_c, dma_req_b, dma_req_a};

	// round robin, search begins right after last
	always_comb begin
		logic [1:0] idx;
		pick       = last;
		pick_valid = 1'b0;
		for (int i = 1; i <= 4; i++) begin
			idx = last + 2'(i);
			if (!pick_valid && req[idx]) begin
				pick       = idx;
				pick_valid = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// beat mux toward intake
	////////////////////////////////////////////////////////////

	always_comb begin
		case (sel)
			2'd0: begin
				sel_valid   = dma_write_valid_a;
				intake_beat = dma_write_data_a;
			end
			2'd1: begin
				sel_valid   = dma_write_valid_b;
				intake_beat = dma_write_data_b;
			end
			2'd2: begin
				sel_valid   = dma_write_valid_c;
				intake_beat = dma_write_data_c;
			end
			default: begin
				sel_valid   = dma_write_valid_d;
				intake_beat = dma_write_data_d;
			end
		endcase
	end

	assign write_ready  = (state == arb_burst) && !intake_full;
	assign accept       = sel_valid && write_ready;
	assign intake_valid = accept;

	// zero length means header only
	assign hdr_len = dma_path_pkg::burst_len_t'(intake_beat >> dma_path_pkg::LEN_LSB);

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state     <= arb_idle;
			sel       <= 2'd0;
			last      <= 2'd3;    // so first search starts at a
			resp_r    <= 1'b0;
			burst_len <= '0;
			beat_cnt  <= '0;
		end else begin
			case (state)
				arb_idle: begin
					if (pick_valid) begin
						sel   <= pick;
						state <= arb_granted;
					end
				end
				arb_granted: begin
					resp_r <= 1'b1;
					state  <= arb_burst;
				end
				arb_burst: begin
					if (accept && resp_r) begin   // header beat
						resp_r    <= 1'b0;
						beat_cnt  <= 16'd1;
						burst_len <= (hdr_len == '0) ? 16'd1 : hdr_len;
						if (hdr_len <= 16'd1)
							state <= arb_done;
					end else if (accept) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt + 1'b1 == burst_len)
							state <= arb_done;
					end
				end
				default: begin
					last  <= sel;   // release grant, one quiet cycle
					state <= arb_idle;
				end
			endcase
		end
	end

	assign dma_resp_a = resp_r && (sel == 2'd0);
	assign dma_resp_b = resp_r && (sel == 2'd1);
	assign dma_resp_c = resp_r && (sel == 2'd2);
	assign dma_resp_d = resp_r && (sel == 2'd3);

	assign dma_write_ready_a = write_ready && (sel == 2'd0);
	assign dma_write_ready_b = write_ready && (sel == 2'd1);
	assign dma_write_ready_c = write_ready && (sel == 2'd2);
	assign dma_write_ready_d = write_ready && (sel == 2'd3);

endmodule

`default_nettype wire

// ==== src/command_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_router (
	input  logic                fpu_clk,
	input  logic                reset,
	input  dma_path_pkg::beat_t intake_beat,
	input  logic                intake_empty,
	output logic                intake_pop,
	output logic                rd_cmd_push,
	output logic                wr_cmd_push,
	output dma_path_pkg::cmd_t  cmd_word,
	input  logic                rd_cmd_full,
	input  logic                wr_cmd_full,
	output logic                data_push,
	output dma_path_pkg::beat_t data_beat,
	input  logic                data_full
);

	typedef enum logic [2:0] {
		rt_header,
		rt_decode,
		rt_push_cmd,
		rt_forward,
		rt_discard
	} rt_state_t;

	rt_state_t                state;
	dma_path_pkg::msg_form_t  form;
	dma_path_pkg::burst_len_t hdr_len;
	dma_path_pkg::burst_len_t remain;    // trailing beats still to move
	logic                     is_write;
	logic                     cmd_push;

	assign hdr_len = dma_path_pkg::burst_len_t'(intake_beat >> dma_path_pkg::LEN_LSB);

	////////////////////////////////////////////////////////////
	// header decode and steering
	////////////////////////////////////////////////////////////

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= rt_header;
			remain   <= '0;
			is_write <= 1'b0;
		end else begin
			case (state)
				rt_header: begin
					if (!intake_empty) begin
						remain <= (hdr_len == '0) ? '0 : hdr_len - 1'b1;
						state  <= rt_decode;
					end
				end
				rt_decode: begin
					is_write <= (form == dma_path_pkg::MSG_WRITE_CMD);
					if (form == dma_path_pkg::MSG_READ_CMD ||
							form == dma_path_pkg::MSG_WRITE_CMD)
						state <= rt_push_cmd;
					else if (remain != '0)
						state <= rt_discard;   // unknown form, drop burst
					else
						state <= rt_header;
				end
				rt_push_cmd: begin
					if (cmd_push) begin
						if (remain == '0)
							state <= rt_header;
						else
							state <= is_write ? rt_forward : rt_discard;
					end
				end
				default: begin   // forward or discard
					if (intake_pop) begin
						remain <= remain - 1'b1;
						if (remain == 16'd1)
							state <= rt_header;
					end
				end
			endcase
		end
	end

	// payload capture
	always_ff @(posedge fpu_clk) begin
		if (state == rt_header && !intake_empty) begin
			cmd_word <= dma_path_pkg::cmd_t'(intake_beat);
			form     <= dma_path_pkg::msg_form_t'(intake_beat >> dma_path_pkg::FORM_LSB);
		end
	end

	assign rd_cmd_push = (state == rt_push_cmd) && !is_write && !rd_cmd_full;
	assign wr_cmd_push = (state == rt_push_cmd) && is_write && !wr_cmd_full;
	assign cmd_push    = rd_cmd_push || wr_cmd_push;

	always_comb begin
		case (state)
			rt_header:  intake_pop = !intake_empty;
			rt_forward: intake_pop = !intake_empty && !data_full;
			rt_discard: intake_pop = !intake_empty;
			default:    intake_pop = 1'b0;
		endcase
	end

	assign data_push = (state == rt_forward) && intake_pop;
	assign data_beat = intake_beat;

endmodule

`default_nettype wire

// ==== src/dram_write_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_write_issuer (
	input  logic                      fpu_clk,
	input  logic                      reset,
	input  dma_path_pkg::cmd_t        cmd_word,
	input  logic                      cmd_empty,
	output logic                      cmd_pop,
	input  dma_path_pkg::beat_t       data_beat,
	input  logic                      data_empty,
	output logic                      data_pop,
	output dma_path_pkg::dram_addr_t  wcc_dram_addr,
	output dma_path_pkg::dpram_addr_t wcc_dpram_addr,
	output dma_path_pkg::burst_len_t  wcc_length,
	output dma_path_pkg::beat_t       wcc_write_data,
	output logic                      wcc_valid,
	input  logic                      wcc_ready
);

	typedef enum logic [1:0] {iss_idle, iss_stream, iss_retire} iss_state_t;

	iss_state_t               state;
	dma_path_pkg::burst_len_t cmd_len;
	dma_path_pkg::burst_len_t remain;   // data beats left in this burst

	assign cmd_len = dma_path_pkg::burst_len_t'(cmd_word >> dma_path_pkg::LEN_LSB);

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state  <= iss_idle;
			remain <= '0;
		end else begin
			case (state)
				iss_idle: begin
					if (!cmd_empty) begin
						remain <= (cmd_len == '0) ? '0 : cmd_len - 1'b1;
						// header only, just retire
						state  <= (cmd_len <= 16'd1) ? iss_retire : iss_stream;
					end
				end
				iss_stream: begin
					if (data_pop) begin
						remain <= remain - 1'b1;
						if (remain == 16'd1)
							state <= iss_retire;
					end
				end
				default: state <= iss_idle;
			endcase
		end
	end

	// command fields held for the whole burst
	always_ff @(posedge fpu_clk) begin
		if (state == iss_idle && !cmd_empty) begin
			wcc_dram_addr  <= dma_path_pkg::dram_addr_t'(cmd_word >> dma_path_pkg::DRAM_ADDR_LSB);
			wcc_dpram_addr <= dma_path_pkg::dpram_addr_t'(cmd_word >> dma_path_pkg::DPRAM_ADDR_LSB);
			wcc_length     <= cmd_len;
		end
	end

	assign wcc_valid      = (state == iss_stream) && !data_empty;
	assign wcc_write_data = data_beat;
	assign data_pop       = wcc_valid && wcc_ready;
	assign cmd_pop        = (state == iss_retire);

endmodule

`default_nettype wire

// ==== src/dma_path_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_path_controller #(
	parameter int INTAKE_DEPTH_LOG2 = 4,
	parameter int CMD_DEPTH_LOG2    = 4,
	parameter int DATA_DEPTH_LOG2   = 4
) (
	input  logic                      fpu_clk,
	input  logic                      reset,
	// clients
	input  logic                      dma_req_a,
	input  logic                      dma_req_b,
	input  logic                      dma_req_c,
	input  logic                      dma_req_d,
	output logic                      dma_resp_a,
	output logic                      dma_resp_b,
	output logic                      dma_resp_c,
	output logic                      dma_resp_d,
	input  logic                      dma_write_valid_a,
	input  logic                      dma_write_valid_b,
	input  logic                      dma_write_valid_c,
	input  logic                      dma_write_valid_d,
	input  dma_path_pkg::beat_t       dma_write_data_a,
	input  dma_path_pkg::beat_t       dma_write_data_b,
	input  dma_path_pkg::beat_t       dma_write_data_c,
	input  dma_path_pkg::beat_t       dma_write_data_d,
	output logic                      dma_write_ready_a,
	output logic                      dma_write_ready_b,
	output logic                      dma_write_ready_c,
	output logic                      dma_write_ready_d,
	// dram read command
	output dma_path_pkg::dram_addr_t  rcc_dram_addr,
	output dma_path_pkg::dpram_addr_t rcc_dpram_addr,
	output dma_path_pkg::burst_len_t  rcc_length,
	output logic                      rcc_valid,
	input  logic                      rcc_ready,
	// dram write
	output dma_path_pkg::dram_addr_t  wcc_dram_addr,
	output dma_path_pkg::dpram_addr_t wcc_dpram_addr,
	output dma_path_pkg::burst_len_t  wcc_length,
	output dma_path_pkg::beat_t       wcc_write_data,
	output logic                      wcc_valid,
	input  logic                      wcc_ready
);

	localparam int BEAT_W = $bits(dma_path_pkg::beat_t);
	localparam int CMD_W  = $bits(dma_path_pkg::cmd_t);

	logic                intake_valid;
	dma_path_pkg::beat_t intake_in;
	logic                intake_full;
	dma_path_pkg::beat_t intake_head;
	logic                intake_empty;
	logic                intake_pop;
	logic                rd_cmd_push;
	logic                wr_cmd_push;
	dma_path_pkg::cmd_t  cmd_word;
	logic                rd_cmd_full;
	logic                wr_cmd_full;
	dma_path_pkg::cmd_t  rd_cmd_head;
	logic                rd_cmd_empty;
	dma_path_pkg::cmd_t  wr_cmd_head;
	logic                wr_cmd_empty;
	logic                wr_cmd_pop;
	logic                data_push;
	dma_path_pkg::beat_t data_in;
	logic                data_full;
	dma_path_pkg::beat_t data_head;
	logic                data_empty;
	logic                data_pop;

	////////////////////////////////////////////////////////////
	// input side
	////////////////////////////////////////////////////////////

	client_arbiter u_arbiter (
		.fpu_clk(fpu_clk), .reset(reset),
		.dma_req_a(dma_req_a), .dma_req_b(dma_req_b),
		.dma_req_c(dma_req_c), .dma_req_d(dma_req_d),
		.dma_write_valid_a(dma_write_valid_a), .dma_write_valid_b(dma_write_valid_b),
		.dma_write_valid_c(dma_write_valid_c), .dma_write_valid_d(dma_write_valid_d),
		.dma_write_data_a(dma_write_data_a), .dma_write_data_b(dma_write_data_b),
		.dma_write_data_c(dma_write_data_c), .dma_write_data_d(dma_write_data_d),
		.dma_resp_a(dma_resp_a), .dma_resp_b(dma_resp_b),
		.dma_resp_c(dma_resp_c), .dma_resp_d(dma_resp_d),
		.dma_write_ready_a(dma_write_ready_a), .dma_write_ready_b(dma_write_ready_b),
		.dma_write_ready_c(dma_write_ready_c), .dma_write_ready_d(dma_write_ready_d),
		.intake_valid(intake_valid), .intake_beat(intake_in), .intake_full(intake_full)
	);

	sync_fifo #(.WIDTH(BEAT_W), .DEPTH_LOG2(INTAKE_DEPTH_LOG2)) u_intake_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.wr_en(intake_valid), .wr_data(intake_in), .full(intake_full),
		.rd_en(intake_pop), .rd_data(intake_head), .empty(intake_empty)
	);

	command_router u_router (
		.fpu_clk(fpu_clk), .reset(reset),
		.intake_beat(intake_head), .intake_empty(intake_empty), .intake_pop(intake_pop),
		.rd_cmd_push(rd_cmd_push), .wr_cmd_push(wr_cmd_push), .cmd_word(cmd_word),
		.rd_cmd_full(rd_cmd_full), .wr_cmd_full(wr_cmd_full),
		.data_push(data_push), .data_beat(data_in), .data_full(data_full)
	);

	////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////

	sync_fifo #(.WIDTH(CMD_W), .DEPTH_LOG2(CMD_DEPTH_LOG2)) u_rd_cmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.wr_en(rd_cmd_push), .wr_data(cmd_word), .full(rd_cmd_full),
		.rd_en(rcc_valid && rcc_ready), .rd_data(rd_cmd_head), .empty(rd_cmd_empty)
	);

	sync_fifo #(.WIDTH(CMD_W), .DEPTH_LOG2(CMD_DEPTH_LOG2)) u_wr_cmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.wr_en(wr_cmd_push), .wr_data(cmd_word), .full(wr_cmd_full),
		.rd_en(wr_cmd_pop), .rd_data(wr_cmd_head), .empty(wr_cmd_empty)
	);

	sync_fifo #(.WIDTH(BEAT_W), .DEPTH_LOG2(DATA_DEPTH_LOG2)) u_wr_data_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.wr_en(data_push), .wr_data(data_in), .full(data_full),
		.rd_en(data_pop), .rd_data(data_head), .empty(data_empty)
	);

	dram_write_issuer u_write_issuer (
		.fpu_clk(fpu_clk), .reset(reset),
		.cmd_word(wr_cmd_head), .cmd_empty(wr_cmd_empty), .cmd_pop(wr_cmd_pop),
		.data_beat(data_head), .data_empty(data_empty), .data_pop(data_pop),
		.wcc_dram_addr(wcc_dram_addr), .wcc_dpram_addr(wcc_dpram_addr),
		.wcc_length(wcc_length), .wcc_write_data(wcc_write_data),
		.wcc_valid(wcc_valid), .wcc_ready(wcc_ready)
	);

	// read commands straight off the fifo head
	assign rcc_valid      = !rd_cmd_empty;
	assign rcc_dram_addr  = dma_path_pkg::dram_addr_t'(rd_cmd_head >> dma_path_pkg::DRAM_ADDR_LSB);
	assign rcc_dpram_addr = dma_path_pkg::dpram_addr_t'(rd_cmd_head >> dma_path_pkg::DPRAM_ADDR_LSB);
	assign rcc_length     = dma_path_pkg::burst_len_t'(rd_cmd_head >> dma_path_pkg::LEN_LSB);

endmodule

`default_nettype wire

// ==== test/dma_path_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_path_assertions (
	input logic                      fpu_clk,
	input logic                      reset,
	input logic                      dma_req_a,
	input logic                      dma_req_b,
	input logic                      dma_req_c,
	input logic                      dma_req_d,
	input logic                      dma_resp_a,
	input logic                      dma_resp_b,
	input logic                      dma_resp_c,
	input logic                      dma_resp_d,
	input logic                      dma_write_ready_a,
	input logic                      dma_write_ready_b,
	input logic                      dma_write_ready_c,
	input logic                      dma_write_ready_d,
	input logic                      rcc_valid,
	input logic                      rcc_ready,
	input dma_path_pkg::dram_addr_t  rcc_dram_addr,
	input dma_path_pkg::dpram_addr_t rcc_dpram_addr,
	input dma_path_pkg::burst_len_t  rcc_length,
	input logic                      wcc_valid,
	input logic                      wcc_ready,
	input dma_path_pkg::dram_addr_t  wcc_dram_addr,
	input dma_path_pkg::dpram_addr_t wcc_dpram_addr,
	input dma_path_pkg::burst_len_t  wcc_length,
	input dma_path_pkg::beat_t       wcc_write_data
);

	// one requesting client at a time
	assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0({dma_resp_a, dma_resp_b, dma_resp_c, dma_resp_d}) &&
		$onehot0({dma_write_ready_a, dma_write_ready_b, dma_write_ready_c, dma_write_ready_d}) &&
		((({dma_resp_a, dma_resp_b, dma_resp_c, dma_resp_d} |
			{dma_write_ready_a, dma_write_ready_b, dma_write_ready_c, dma_write_ready_d}) &
			~{dma_req_a, dma_req_b, dma_req_c, dma_req_d}) == 4'b0000))
		else $error("resp or ready seen by more than one client or by an idle client");

	assert property (@(posedge fpu_clk) disable iff (reset)
		wcc_valid && !wcc_ready |=> wcc_valid && $stable(wcc_write_data) &&
			$stable({wcc_dram_addr, wcc_dpram_addr, wcc_length}))
		else $error("wcc beat changed or dropped before wcc_ready");

	assert property (@(posedge fpu_clk) disable iff (reset)
		rcc_valid && !rcc_ready |=> rcc_valid &&
			$stable({rcc_dram_addr, rcc_dpram_addr, rcc_length}))
		else $error("rcc command changed or dropped before rcc_ready");

	// quiet outputs on the first edge out of reset
	assert property (@(posedge fpu_clk) $fell(reset) |->
		({dma_resp_a, dma_resp_b, dma_resp_c, dma_resp_d, dma_write_ready_a, dma_write_ready_b,
			dma_write_ready_c, dma_write_ready_d, rcc_valid, wcc_valid} == '0))
		else $error("output high right after reset");

endmodule

`default_nettype wire

// ==== test/tb_dma_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma_path;

	localparam int TOTAL_BEATS = 5 + 1 + 4 + 12 + 4 + 33;   // all bursts of all tests

	logic                      fpu_clk;
	logic                      reset;
	logic [3:0]                req;
	logic [3:0]                valid;
	dma_path_pkg::beat_t       wdata [4];
	wire  [3:0]                resp;
	wire  [3:0]                ready;
	dma_path_pkg::dram_addr_t  rcc_dram_addr;
	dma_path_pkg::dpram_addr_t rcc_dpram_addr;
	dma_path_pkg::burst_len_t  rcc_length;
	logic                      rcc_valid;
	logic                      rcc_ready;
	dma_path_pkg::dram_addr_t  wcc_dram_addr;
	dma_path_pkg::dpram_addr_t wcc_dpram_addr;
	dma_path_pkg::burst_len_t  wcc_length;
	dma_path_pkg::beat_t       wcc_write_data;
	logic                      wcc_valid;
	logic                      wcc_ready;
	bit                        random_ready = 1'b0;

	dma_path_pkg::beat_t sent_q [4][$];   // per client, header first
	dma_path_pkg::cmd_t  wcmd_q[$];
	dma_path_pkg::beat_t wdata_q[$];
	dma_path_pkg::cmd_t  rcmd_q[$];
	dma_path_pkg::cmd_t  exp_wcmd_q[$];
	dma_path_pkg::beat_t exp_wdata_q[$];
	dma_path_pkg::cmd_t  exp_rcmd_q[$];

	dma_path_controller DUT (
		.fpu_clk(fpu_clk), .reset(reset),
		.dma_req_a(req[0]), .dma_req_b(req[1]), .dma_req_c(req[2]), .dma_req_d(req[3]),
		.dma_resp_a(resp[0]), .dma_resp_b(resp[1]), .dma_resp_c(resp[2]), .dma_resp_d(resp[3]),
		.dma_write_valid_a(valid[0]), .dma_write_valid_b(valid[1]),
		.dma_write_valid_c(valid[2]), .dma_write_valid_d(valid[3]),
		.dma_write_data_a(wdata[0]), .dma_write_data_b(wdata[1]),
		.dma_write_data_c(wdata[2]), .dma_write_data_d(wdata[3]),
		.dma_write_ready_a(ready[0]), .dma_write_ready_b(ready[1]),
		.dma_write_ready_c(ready[2]), .dma_write_ready_d(ready[3]),
		.rcc_dram_addr(rcc_dram_addr), .rcc_dpram_addr(rcc_dpram_addr),
		.rcc_length(rcc_length), .rcc_valid(rcc_valid), .rcc_ready(rcc_ready),
		.wcc_dram_addr(wcc_dram_addr), .wcc_dpram_addr(wcc_dpram_addr),
		.wcc_length(wcc_length), .wcc_write_data(wcc_write_data),
		.wcc_valid(wcc_valid), .wcc_ready(wcc_ready)
	);

	bind dma_path_controller dma_path_assertions u_assertions (.*);

	initial begin
		fpu_clk = 1'b0;
		forever #2 fpu_clk = ~fpu_clk;
	end

	// dram side ready, random only during the stress test
	initial begin
		wcc_ready = 1'b1;
		rcc_ready = 1'b1;
		forever begin
			@(posedge fpu_clk);
			#1;
			wcc_ready = random_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
			rcc_ready = random_ready ? ($urandom_range(0, 1) != 0) : 1'b1;
		end
	end

	// dram monitors, mid cycle so nothing races the edge
	always @(negedge fpu_clk) begin
		if (wcc_valid && wcc_ready) begin
			wcmd_q.push_back({wcc_length, wcc_dpram_addr, wcc_dram_addr});
			wdata_q.push_back(wcc_write_data);
		end
		if (rcc_valid && rcc_ready)
			rcmd_q.push_back({rcc_length, rcc_dpram_addr, rcc_dram_addr});
	end

	initial begin
		repeat (TOTAL_BEATS * 60 + 200) @(posedge fpu_clk);
		$display("timeout: DRAM side outputs did not all arrive");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_cmd(input string name, input dma_path_pkg::cmd_t exp,
			input dma_path_pkg::cmd_t got);
		if (got !== exp) begin
			$display("error %s: expected command %h, got %h", name, exp, got);
			$display(">>> FAIL");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic check_beat(input string name, input dma_path_pkg::beat_t exp,
			input dma_path_pkg::beat_t got);
		if (got !== exp) begin
			$display("error %s: expected beat %h, got %h", name, exp, got);
			$display(">>> FAIL");
			$fatal(1, "beat mismatch");
		end
	endtask

	task automatic check_len(input string name, input dma_path_pkg::burst_len_t exp,
			input dma_path_pkg::burst_len_t got);
		if (got !== exp) begin
			$display("error %s: expected count %0d, got %0d", name, exp, got);
			$display(">>> FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_flags(input string name, input logic [9:0] exp, input logic [9:0] got);
		if (got !== exp) begin
			$display("error %s: expected flags %b, got %b", name, exp, got);
			$display(">>> FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// client driver and expected results
	////////////////////////////////////////////////////////////

	task automatic send_burst(input int c, input dma_path_pkg::msg_form_t form,
			input dma_path_pkg::burst_len_t len, input dma_path_pkg::dram_addr_t dram,
			input dma_path_pkg::dpram_addr_t dpram);
		dma_path_pkg::beat_t beats[$];
		logic                accepted;
		beats.push_back({48'h0, form, len, dpram, dram});
		for (int i = 1; i < int'(len); i++)
			beats.push_back({$urandom, $urandom, $urandom, $urandom});
		sent_q[c] = beats;
		@(posedge fpu_clk);
		#1;
		req[c] = 1'b1;
		do @(negedge fpu_clk); while (!resp[c]);   // wait for grant
		@(posedge fpu_clk);
		#1;
		foreach (beats[i]) begin
			valid[c] = 1'b1;
			wdata[c] = beats[i];
			do begin
				@(negedge fpu_clk);
				accepted = ready[c];   // ready is settled mid cycle
				@(posedge fpu_clk);
				#1;
			end while (!accepted);
		end
		valid[c] = 1'b0;
		req[c]   = 1'b0;
	endtask

	// what the dram side should see for a client's last burst
	task automatic expect_burst(input int c);
		dma_path_pkg::beat_t     hdr;
		dma_path_pkg::msg_form_t form;
		hdr  = sent_q[c].pop_front();
		form = hdr[dma_path_pkg::FORM_LSB +: 8];
		if (form == dma_path_pkg::MSG_READ_CMD)
			exp_rcmd_q.push_back(hdr[71:0]);
		while (sent_q[c].size() > 0) begin
			if (form == dma_path_pkg::MSG_WRITE_CMD) begin
				exp_wcmd_q.push_back(hdr[71:0]);
				exp_wdata_q.push_back(sent_q[c].pop_front());
			end else begin
				void'(sent_q[c].pop_front());   // trailing beats dropped
			end
		end
	endtask

	task automatic compare_outputs(input string name);
		while (wdata_q.size() < exp_wdata_q.size() || rcmd_q.size() < exp_rcmd_q.size())
			@(negedge fpu_clk);
		check_len({name, " write beats"}, dma_path_pkg::burst_len_t'(exp_wdata_q.size()),
			dma_path_pkg::burst_len_t'(wdata_q.size()));
		check_len({name, " read commands"}, dma_path_pkg::burst_len_t'(exp_rcmd_q.size()),
			dma_path_pkg::burst_len_t'(rcmd_q.size()));
		while (exp_wdata_q.size() > 0) begin
			check_cmd(name, exp_wcmd_q.pop_front(), wcmd_q.pop_front());
			check_beat(name, exp_wdata_q.pop_front(), wdata_q.pop_front());
		end
		while (exp_rcmd_q.size() > 0)
			check_cmd(name, exp_rcmd_q.pop_front(), rcmd_q.pop_front());
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_single_write();
		@(negedge fpu_clk);
		check_flags("single_write reset", '0, {resp, ready, rcc_valid, wcc_valid});
		send_burst(0, dma_path_pkg::MSG_WRITE_CMD, 16'd5, 40'h12_3456_7800, 16'h0040);
		expect_burst(0);
		compare_outputs("single_write");
	endtask

	task automatic test_single_read();
		send_burst(2, dma_path_pkg::MSG_READ_CMD, 16'd1, 40'h00_0ABC_D000, 16'h1230);
		expect_burst(2);
		compare_outputs("single_read");
	endtask

	// unknown form, then a read behind it; leaves d as last served
	task automatic test_discard();
		send_burst(1, 8'h02, 16'd3, 40'h00_DEAD_0000, 16'h0200);
		send_burst(3, dma_path_pkg::MSG_READ_CMD, 16'd1, 40'h00_0000_F000, 16'h0300);
		expect_burst(1);
		expect_burst(3);
		compare_outputs("discard");
	endtask

	task automatic test_round_robin();
		fork
			send_burst(0, dma_path_pkg::MSG_WRITE_CMD, 16'd3, 40'h00_0000_A000, 16'h0A00);
			send_burst(1, dma_path_pkg::MSG_WRITE_CMD, 16'd3, 40'h00_0000_B000, 16'h0B00);
			send_burst(2, dma_path_pkg::MSG_WRITE_CMD, 16'd3, 40'h00_0000_C000, 16'h0C00);
			send_burst(3, dma_path_pkg::MSG_WRITE_CMD, 16'd3, 40'h00_0000_D000, 16'h0D00);
		join
		for (int c = 0; c < 4; c++)
			expect_burst(c);
		compare_outputs("round_robin_all");
		fork
			send_burst(3, dma_path_pkg::MSG_WRITE_CMD, 16'd2, 40'h00_0000_D100, 16'h0D10);
			send_burst(1, dma_path_pkg::MSG_WRITE_CMD, 16'd2, 40'h00_0000_B100, 16'h0B10);
		join
		expect_burst(1);   // d was just served
		expect_burst(3);
		compare_outputs("round_robin_after_d");
	endtask

	task automatic test_backpressure();
		random_ready = 1'b1;
		fork
			send_burst(0, dma_path_pkg::MSG_WRITE_CMD, 16'd6, 40'h01_0000_0000, 16'h4000);
			send_burst(1, dma_path_pkg::MSG_READ_CMD, 16'd3, 40'h02_0000_0000, 16'h5000);
			send_burst(2, dma_path_pkg::MSG_WRITE_CMD, 16'd20, 40'h03_0000_0000, 16'h6000);
			send_burst(3, dma_path_pkg::MSG_WRITE_CMD, 16'd4, 40'h04_0000_0000, 16'h7000);
		join
		for (int c = 0; c < 4; c++)
			expect_burst(c);
		compare_outputs("backpressure");
		random_ready = 1'b0;
	endtask

	initial begin
		void'($urandom(25377));
		reset = 1'b1;
		req   = '0;
		valid = '0;
		for (int i = 0; i < 4; i++)
			wdata[i] = '0;
		repeat (8) @(posedge fpu_clk);
		#1;
		reset = 1'b0;
		test_single_write();
		test_single_read();
		test_discard();
		test_round_robin();
		test_backpressure();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
src/dma_path_pkg.sv
src/sync_fifo.sv
src/client_arbiter.sv
src/command_router.sv
src/dram_write_issuer.sv
src/dma_path_controller.sv
test/dma_path_assertions.sv
test/tb_dma_path.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dma_path -f build.f -o sim_dma_path

./obj_dir/sim_dma_path
